//--- compile.f
source/noc_cong_pkg.sv
source/ovc_busy_counter.sv
source/ivc_stall_counter.sv
source/congestion_combiner.sv
source/port_presel.sv
source/deadlock_detector.sv
source/congestion_analyzer.sv
dv/congestion_analyzer_tb.sv

//--- dv/congestion_analyzer_tb.sv
`timescale 1ns/1ps

module congestion_analyzer_tb;

    localparam int CLK_PERIOD    = 10;
    localparam int STALL_PENALTY = 3;  // one request left waiting
    localparam int BAND          = noc_cong_pkg::MAX_CONG_SUM / (1 << noc_cong_pkg::CONG_W);
    localparam int RUN_LIMIT     = 5000;  // cycles before the run is declared hung

    logic                         clk;
    logic                         rst_n;
    noc_cong_pkg::router_status_t status;
    noc_cong_pkg::cong_all_t      neighbor_cong;
    noc_cong_pkg::cong_all_t      cong_out;
    noc_cong_pkg::presel_t        port_pre_sel;
    logic                         deadlock;

    integer seed        = 32'h95a3_6f6a;

    congestion_analyzer congestion_analyzer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .status        (status),
        .neighbor_cong (neighbor_cong),
        .cong_out      (cong_out),
        .port_pre_sel  (port_pre_sel),
        .deadlock      (deadlock)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("simulation ran past its cycle limit without finishing");
        abort_run();
    end

    // all tasks start and end on a falling edge
    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic check_cong(input string                   test_name,
                              input noc_cong_pkg::cong_all_t expected,
                              input noc_cong_pkg::cong_all_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: cong_out expected %h, actual %h", test_name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_presel(input string                 test_name,
                                input noc_cong_pkg::presel_t expected,
                                input noc_cong_pkg::presel_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: port_pre_sel expected %b, actual %b",
                     test_name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string test_name,
                             input logic  expected,
                             input logic  actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: deadlock expected %b, actual %b", test_name, expected, actual);
            abort_run();
        end
    endtask

    // reference model

    function automatic int count_busy(input noc_cong_pkg::router_status_t s, input int d);
        int n;
        n = 0;
        for (int m = 0; m < noc_cong_pkg::NUM_MESH; m++) begin
            if (m != d) begin
                for (int v = 0; v < noc_cong_pkg::NUM_VCS; v++) begin
                    if (!s.ovc_available[m + 1][v]) begin
                        n++;
                    end
                end
            end
        end
        return n;
    endfunction

    function automatic int count_waiting(input noc_cong_pkg::router_status_t s, input int d);
        int n;
        n = 0;
        for (int v = 0; v < noc_cong_pkg::NUM_VCS; v++) begin
            if (s.ivc_request[d + 1][v] && !s.ivc_grant[d + 1][v]) begin
                n++;
            end
        end
        return n;
    endfunction

    // eight bands of three, the first one holds 0..3
    function automatic noc_cong_pkg::cong_t band_of(input int n);
        noc_cong_pkg::cong_t level;
        level = '0;
        for (int i = 1; i < (1 << noc_cong_pkg::CONG_W); i++) begin
            if (n > BAND * i && n <= BAND * (i + 1)) begin
                level = i;
            end
        end
        return level;
    endfunction

    function automatic noc_cong_pkg::cong_all_t model_cong(
        input noc_cong_pkg::router_status_t s);
        noc_cong_pkg::cong_all_t levels;
        levels = '0;  // local slot stays 0
        for (int d = 0; d < noc_cong_pkg::NUM_MESH; d++) begin
            levels[d + 1] = band_of(count_busy(s, d) + STALL_PENALTY * count_waiting(s, d));
        end
        return levels;
    endfunction

    function automatic noc_cong_pkg::presel_t model_presel(
        input noc_cong_pkg::cong_all_t nc);
        noc_cong_pkg::presel_t p;
        noc_cong_pkg::cong_t   e;
        noc_cong_pkg::cong_t   n;
        noc_cong_pkg::cong_t   w;
        noc_cong_pkg::cong_t   s;
        e = nc[noc_cong_pkg::EAST + 1];
        n = nc[noc_cong_pkg::NORTH + 1];
        w = nc[noc_cong_pkg::WEST + 1];
        s = nc[noc_cong_pkg::SOUTH + 1];
        p = '0;
        p[noc_cong_pkg::Q_XP_YP] = (e > n);
        p[noc_cong_pkg::Q_XM_YP] = (w > n);
        p[noc_cong_pkg::Q_XP_YM] = (e > s);
        p[noc_cong_pkg::Q_XM_YM] = (w > s);
        return p;
    endfunction

    // stimulus helpers

    function automatic noc_cong_pkg::router_status_t idle_status();
        noc_cong_pkg::router_status_t s;
        s               = '0;
        s.ovc_available = '1;  // every output vc free
        return s;
    endfunction

    function automatic noc_cong_pkg::port_vc_t random_vc_field();
        noc_cong_pkg::port_vc_t f;
        f = $random(seed);
        return f;
    endfunction

    function automatic noc_cong_pkg::cong_all_t random_levels();
        noc_cong_pkg::cong_all_t c;
        c = $random(seed);
        return c;
    endfunction

    // tests

    task automatic test_reset();
        rst_n         = 1'b0;
        status        = '0;
        status.ivc_request = random_vc_field();
        neighbor_cong = random_levels();
        wait_cycles(2);
        check_cong("test_reset", '0, cong_out);
        check_presel("test_reset", '0, port_pre_sel);
        check_bit("test_reset", 1'b0, deadlock);
        rst_n         = 1'b1;
        status        = idle_status();
        neighbor_cong = '0;
        wait_cycles(1);
        check_cong("test_reset", '0, cong_out);
        check_presel("test_reset", '0, port_pre_sel);
        check_bit("test_reset", 1'b0, deadlock);
    endtask

    task automatic test_ovc_busy();
        noc_cong_pkg::router_status_t s;
        noc_cong_pkg::cong_all_t      top_band;
        for (int k = 0; k < 12; k++) begin
            s               = idle_status();
            s.ovc_available = random_vc_field();
            status          = s;
            wait_cycles(2);
            check_cong("test_ovc_busy", model_cong(s), cong_out);
        end
        // everything taken and every request stuck
        s             = '0;
        s.ivc_request = '1;
        status        = s;
        wait_cycles(3);
        top_band = '0;
        for (int p = 1; p < noc_cong_pkg::NUM_PORTS; p++) begin
            top_band[p] = 3'd7;
        end
        check_cong("test_ovc_busy", top_band, cong_out);
        status = idle_status();
        wait_cycles(3);
        check_cong("test_ovc_busy", '0, cong_out);
    endtask

    task automatic test_ivc_stall();
        noc_cong_pkg::router_status_t s;
        for (int k = 0; k < 20; k++) begin
            s = idle_status();
            if (k % 3 == 1) begin
                s.ovc_available = random_vc_field();
            end
            s.ivc_request = random_vc_field();
            s.ivc_grant   = s.ivc_request & random_vc_field();  // partial grants
            status        = s;
            wait_cycles(3);
            check_cong("test_ivc_stall", model_cong(s), cong_out);
        end
        status = idle_status();
        wait_cycles(3);
    endtask

    task automatic test_port_presel();
        noc_cong_pkg::cong_all_t nc;
        for (int k = 0; k < 24; k++) begin
            nc = random_levels();
            if (k % 3 == 0) begin
                nc[noc_cong_pkg::NORTH + 1] = nc[noc_cong_pkg::EAST + 1];  // ties
                nc[noc_cong_pkg::SOUTH + 1] = nc[noc_cong_pkg::WEST + 1];
            end
            neighbor_cong = nc;
            wait_cycles(1);
            check_presel("test_port_presel", model_presel(nc), port_pre_sel);
        end
        neighbor_cong = '0;
        wait_cycles(1);
    endtask

    task automatic test_deadlock();
        noc_cong_pkg::router_status_t s;
        int                           vc;
        int                           port;
        int                           cycles;
        bit                           seen;
        vc   = $unsigned($random(seed)) % noc_cong_pkg::NUM_VCS;
        port = 1 + $unsigned($random(seed)) % noc_cong_pkg::NUM_MESH;
        // grants on every vc flush the watchdogs
        s           = idle_status();
        s.ivc_grant = '1;
        status      = s;
        wait_cycles(2);
        s                        = idle_status();
        s.ivc_request[port][vc]  = 1'b1;
        status                   = s;
        check_bit("test_deadlock", 1'b0, deadlock);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 2 * noc_cong_pkg::MAX_CLK) begin
            @(negedge clk);
            cycles++;
            if (deadlock) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("test_deadlock: deadlock never rose while a request waited without grant");
            abort_run();
        end
        if (cycles < noc_cong_pkg::MAX_CLK - 1) begin
            $display("test_deadlock: deadlock rose after only %0d cycles", cycles);
            abort_run();
        end
        // request served by a one cycle grant pulse
        s.ivc_request[port][vc] = 1'b0;
        s.ivc_grant[port][vc]   = 1'b1;
        status                  = s;
        wait_cycles(1);
        check_bit("test_deadlock", 1'b1, deadlock);  // grant still in its register
        s.ivc_grant = '0;
        status      = s;
        wait_cycles(1);
        check_bit("test_deadlock", 1'b0, deadlock);
        status = idle_status();
        wait_cycles(2);
    endtask

    initial begin
        rst_n         = 1'b0;
        status        = idle_status();
        neighbor_cong = '0;
        test_reset();
        test_ovc_busy();
        test_ivc_stall();
        test_port_presel();
        test_deadlock();
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- source/congestion_analyzer.sv
`timescale 1ns/1ps

module congestion_analyzer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  noc_cong_pkg::router_status_t status,
    input  noc_cong_pkg::cong_all_t      neighbor_cong,
    output noc_cong_pkg::cong_all_t      cong_out,
    output noc_cong_pkg::presel_t        port_pre_sel,
    output logic                         deadlock
);

    noc_cong_pkg::busy_cnt_t  busy;   // taken ovcs, three other ports
    noc_cong_pkg::stall_cnt_t stall;  // requests left waiting, registered

    ovc_busy_counter ovc_busy_counter_inst (
        .status (status),
        .busy   (busy)
    );

    ivc_stall_counter ivc_stall_counter_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .status (status),
        .stall  (stall)
    );

    congestion_combiner congestion_combiner_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .busy     (busy),
        .stall    (stall),
        .cong_out (cong_out)
    );

    // driven only by what the neighbors report
    port_presel port_presel_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .neighbor_cong (neighbor_cong),
        .port_pre_sel  (port_pre_sel)
    );

    deadlock_detector deadlock_detector_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .status   (status),
        .deadlock (deadlock)
    );

endmodule

//--- source/congestion_combiner.sv
`timescale 1ns/1ps

module congestion_combiner (
    input  logic                     clk,
    input  logic                     rst_n,
    input  noc_cong_pkg::busy_cnt_t  busy,
    input  noc_cong_pkg::stall_cnt_t stall,
    output noc_cong_pkg::cong_all_t  cong_out
);

    logic [noc_cong_pkg::NUM_MESH-1:0][noc_cong_pkg::SUM_W-1:0] cong_sum;
    noc_cong_pkg::cong_all_t                                    cong_next;

    // weighted load, stalled requests count three times
    always_comb begin
        for (int m = 0; m < noc_cong_pkg::NUM_MESH; m++) begin
            cong_sum[m] = busy[m] + noc_cong_pkg::STALL_WEIGHT * stall[m];
        end
    end

    // split the full range into 2**CONG_W equal bands.
    // band 0 covers 0..3, band i covers 3i+1..3(i+1)
    always_comb begin
        cong_next = '0;  // local port never reports
        for (int m = 0; m < noc_cong_pkg::NUM_MESH; m++) begin
            for (int i = 1; i < (1 << noc_cong_pkg::CONG_W); i++) begin
                if (cong_sum[m] > ((noc_cong_pkg::MAX_CONG_SUM * i) >> noc_cong_pkg::CONG_W)) begin
                    cong_next[m + 1] = i[noc_cong_pkg::CONG_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cong_out <= '0;
        end else begin
            cong_out <= cong_next;
        end
    end

endmodule

//--- source/deadlock_detector.sv
`timescale 1ns/1ps

module deadlock_detector (
    input  logic                         clk,
    input  logic                         rst_n,
    input  noc_cong_pkg::router_status_t status,
    output logic                         deadlock
);

    noc_cong_pkg::port_vc_t                                         grant_q;
    logic [noc_cong_pkg::NUM_VCS-1:0]                               wd_clr;   // any port granted vc
    logic [noc_cong_pkg::NUM_VCS-1:0]                               wd_en;    // any port waits on vc
    logic [noc_cong_pkg::NUM_VCS-1:0]                               wd_hit;
    logic [noc_cong_pkg::NUM_VCS-1:0][noc_cong_pkg::WD_CNT_W-1:0]   wd_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_q <= '0;
        end else begin
            grant_q <= status.ivc_grant;
        end
    end

    // fold all ports onto one watchdog per vc index
    always_comb begin
        wd_clr = '0;
        wd_en  = '0;
        for (int v = 0; v < noc_cong_pkg::NUM_VCS; v++) begin
            for (int p = 0; p < noc_cong_pkg::NUM_PORTS; p++) begin
                wd_clr[v] = wd_clr[v] | grant_q[p][v];
                wd_en[v]  = wd_en[v] | status.ivc_request[p][v];
            end
        end
    end

    // clear wins over count, counter wraps
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wd_cnt <= '0;
        end else begin
            for (int v = 0; v < noc_cong_pkg::NUM_VCS; v++) begin
                if (wd_clr[v]) begin
                    wd_cnt[v] <= '0;
                end else if (wd_en[v]) begin
                    wd_cnt[v] <= wd_cnt[v] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int v = 0; v < noc_cong_pkg::NUM_VCS; v++) begin
            wd_hit[v] = (wd_cnt[v] == (noc_cong_pkg::MAX_CLK - 1));
        end
    end

    assign deadlock = |wd_hit;

endmodule

//--- source/ivc_stall_counter.sv
`timescale 1ns/1ps

module ivc_stall_counter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  noc_cong_pkg::router_status_t status,
    output noc_cong_pkg::stall_cnt_t     stall
);

    noc_cong_pkg::vc_vec_t [noc_cong_pkg::NUM_MESH-1:0] stall_q;  // waited last cycle

    // capture requests that lost arbitration
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_q <= '0;
        end else begin
            for (int m = 0; m < noc_cong_pkg::NUM_MESH; m++) begin
                stall_q[m] <= status.ivc_request[m + 1] & ~status.ivc_grant[m + 1];
            end
        end
    end

    // popcount per mesh port
    always_comb begin
        for (int m = 0; m < noc_cong_pkg::NUM_MESH; m++) begin
            stall[m] = '0;
            for (int v = 0; v < noc_cong_pkg::NUM_VCS; v++) begin
                stall[m] = stall[m] + stall_q[m][v];
            end
        end
    end

endmodule

//--- source/noc_cong_pkg.sv
package noc_cong_pkg;

    // router geometry
    localparam int NUM_PORTS = 5;  // port 0 is local
    localparam int NUM_VCS   = 4;
    localparam int NUM_MESH  = 4;  // east, north, west, south

    // congestion level
    localparam int CONG_W       = 3;
    localparam int MAX_CONG_SUM = 6 * NUM_VCS;  // 3 ports of vcs plus 3x weighted stalls

    // watchdog limit in cycles
    localparam int MAX_CLK = 16;

    // count widths
    localparam int BUSY_CNT_W  = $clog2(3 * NUM_VCS + 1);
    localparam int STALL_CNT_W = $clog2(NUM_VCS + 1);
    localparam int SUM_W       = $clog2(MAX_CONG_SUM + 1);
    localparam int WD_CNT_W    = $clog2(MAX_CLK);

    // weight of one request left waiting, sized to the sum
    localparam logic [SUM_W-1:0] STALL_WEIGHT = 3;

    // mesh index k sits on router port k+1
    localparam int EAST  = 0;
    localparam int NORTH = 1;
    localparam int WEST  = 2;
    localparam int SOUTH = 3;

    // quadrant positions in the preselect word
    localparam int Q_XM_YM = 0;
    localparam int Q_XM_YP = 1;
    localparam int Q_XP_YM = 2;
    localparam int Q_XP_YP = 3;

    typedef logic [NUM_VCS-1:0] vc_vec_t;              // one bit per vc
    typedef vc_vec_t [NUM_PORTS-1:0] port_vc_t;        // indexed by router port

    typedef struct packed {
        port_vc_t ovc_available;  // 1 = output vc free
        port_vc_t ivc_request;    // input vc asks for the switch
        port_vc_t ivc_grant;      // input vc won the switch this cycle
    } router_status_t;

    typedef logic [CONG_W-1:0] cong_t;                 // 0 = least congested
    typedef cong_t [NUM_PORTS-1:0] cong_all_t;         // local slot held at 0

    typedef logic [NUM_MESH-1:0][BUSY_CNT_W-1:0]  busy_cnt_t;
    typedef logic [NUM_MESH-1:0][STALL_CNT_W-1:0] stall_cnt_t;

    typedef logic [3:0] presel_t;                      // 1 = prefer y, 0 = prefer x

endpackage

//--- source/ovc_busy_counter.sv
`timescale 1ns/1ps

module ovc_busy_counter (
    input  noc_cong_pkg::router_status_t status,
    output noc_cong_pkg::busy_cnt_t      busy
);

    noc_cong_pkg::vc_vec_t [noc_cong_pkg::NUM_MESH-1:0] ovc_busy;  // 1 = output vc taken

    // mesh ports only, local port skipped
    always_comb begin
        for (int m = 0; m < noc_cong_pkg::NUM_MESH; m++) begin
            ovc_busy[m] = ~status.ovc_available[m + 1];
        end
    end

    // for port d, sum the taken vcs on the other three mesh ports.
    // that is the load a packet meets when it turns away from d
    always_comb begin
        for (int d = 0; d < noc_cong_pkg::NUM_MESH; d++) begin
            busy[d] = '0;
            for (int m = 0; m < noc_cong_pkg::NUM_MESH; m++) begin
                if (m != d) begin
                    for (int v = 0; v < noc_cong_pkg::NUM_VCS; v++) begin
                        busy[d] = busy[d] + ovc_busy[m][v];
                    end
                end
            end
        end
    end

endmodule

//--- source/port_presel.sv
`timescale 1ns/1ps

module port_presel (
    input  logic                    clk,
    input  logic                    rst_n,
    input  noc_cong_pkg::cong_all_t neighbor_cong,
    output noc_cong_pkg::presel_t   port_pre_sel
);

    noc_cong_pkg::cong_t   cong_e;
    noc_cong_pkg::cong_t   cong_n;
    noc_cong_pkg::cong_t   cong_w;
    noc_cong_pkg::cong_t   cong_s;
    noc_cong_pkg::presel_t presel_next;

    // router port = mesh index + 1, local slot dropped
    assign cong_e = neighbor_cong[noc_cong_pkg::EAST + 1];
    assign cong_n = neighbor_cong[noc_cong_pkg::NORTH + 1];
    assign cong_w = neighbor_cong[noc_cong_pkg::WEST + 1];
    assign cong_s = neighbor_cong[noc_cong_pkg::SOUTH + 1];

    // go y only when the x neighbor is strictly worse, ties stay on x
    always_comb begin
        presel_next                        = '0;
        presel_next[noc_cong_pkg::Q_XP_YP] = (cong_e > cong_n);
        presel_next[noc_cong_pkg::Q_XM_YP] = (cong_w > cong_n);
        presel_next[noc_cong_pkg::Q_XP_YM] = (cong_e > cong_s);
        presel_next[noc_cong_pkg::Q_XM_YM] = (cong_w > cong_s);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            port_pre_sel <= '0;
        end else begin
            port_pre_sel <= presel_next;
        end
    end

endmodule
